// File: compile.f
+incdir+src
src/fir_pkg.sv
src/window_if.sv
src/sliding_window.sv
src/window_sequencer.sv
src/coef_bank.sv
src/mac_tree.sv
src/simd_fir_top.sv
verif/simd_fir_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the SIMD FIR testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary -Wno-fatal -f compile.f --top-module simd_fir_tb -o simd_fir_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simd_fir_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// File: src/coef_bank.sv
// Coefficient bank
// one coefficient written per strobe, all of them presented in parallel

`timescale 1ns/100ps
`default_nettype none

`include "fir_cfg.svh"

module coef_bank
    import fir_pkg::*;
(
    input  wire             clock,
    input  wire             rst,
    input  wire             coef_write,
    input  wire coef_addr_t coef_addr,
    input  wire coef_t      coef_data,
    output coef_vec_t       coefs
);

    localparam int LANES = `FIR_LANES;

    // address decode, one enable per lane
    logic [LANES-1:0] lane_write;

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            lane_write[k] = coef_write && (coef_addr == coef_addr_t'(k));
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            coefs <= '0;
        end else begin
            for (int k = 0; k < LANES; k++) begin
                if (lane_write[k]) begin
                    coefs[k] <= coef_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/fir_cfg.svh
// FIR configuration
// sample, coefficient and accumulator widths, and the lane count

`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// one input sample
`define FIR_SAMPLE_WIDTH 16

// one coefficient
`define FIR_COEF_WIDTH 16

// samples per block, also the tap count
`define FIR_LANES 4

// product width plus two bits of growth for four lanes
`define FIR_ACC_WIDTH 34

`define FIR_COEF_ADDR_WIDTH 2

`endif

// File: src/fir_pkg.sv
// FIR types
// vector types shared by the window, the sequencer and the multiply-add tree

`default_nettype none

`include "fir_cfg.svh"

package fir_pkg;

    typedef logic [`FIR_SAMPLE_WIDTH-1:0]       sample_t;
    typedef logic [`FIR_COEF_WIDTH-1:0]         coef_t;
    typedef logic [`FIR_ACC_WIDTH-1:0]          acc_t;
    typedef logic [`FIR_COEF_ADDR_WIDTH-1:0]    coef_addr_t;

    // lane 0 is the oldest sample of a block
    typedef sample_t [`FIR_LANES-1:0]           block_t;
    // lane k weights the sample k reads old
    typedef coef_t [`FIR_LANES-1:0]             coef_vec_t;

    // samples left in the write window, 0 to LANES
    typedef logic [$clog2(`FIR_LANES+1)-1:0]    count_t;

    typedef enum logic {
        seq_empty,
        seq_stream
    } seq_state_t;

endpackage

`default_nettype wire

// File: src/mac_tree.sv
// Multiply-add tree
// per-lane signed products and their sum, two register stages after the window

`timescale 1ns/100ps
`default_nettype none

`include "fir_cfg.svh"

module mac_tree
    import fir_pkg::*;
(
    input  wire             clock,
    input  wire             rst,
    window_if.tap           bus,
    input  wire coef_vec_t  coefs,
    output logic            y_valid,
    output acc_t            y
);

    localparam int LANES      = `FIR_LANES;
    localparam int PROD_WIDTH = `FIR_SAMPLE_WIDTH + `FIR_COEF_WIDTH;
    localparam int EXT_WIDTH  = `FIR_ACC_WIDTH - PROD_WIDTH;

    // window changed on the previous edge
    logic fresh;
    logic prod_valid;

    logic signed [PROD_WIDTH-1:0] prod [LANES];
    acc_t                         sum;

    // valid follows the data through both stages
    always_ff @(posedge clock) begin
        if (rst) begin
            fresh      <= 1'b0;
            prod_valid <= 1'b0;
            y_valid    <= 1'b0;
        end else begin
            fresh      <= bus.read;
            prod_valid <= fresh;
            y_valid    <= prod_valid;
        end
    end

    // stage 1, one product per lane
    always_ff @(posedge clock) begin
        if (fresh) begin
            for (int k = 0; k < LANES; k++) begin
                prod[k] <= $signed(bus.window[k]) * $signed(coefs[k]);
            end
        end
    end

    // sign-extended sum over all lanes
    always_comb begin
        sum = '0;
        for (int k = 0; k < LANES; k++) begin
            sum = sum + {{EXT_WIDTH{prod[k][PROD_WIDTH-1]}}, prod[k]};
        end
    end

    // stage 2
    always_ff @(posedge clock) begin
        if (prod_valid) begin
            y <= sum;
        end
    end

endmodule

`default_nettype wire

// File: src/simd_fir_top.sv
// SIMD FIR filter
// block-written samples through a sliding window into a multiply-add tree

`timescale 1ns/100ps
`default_nettype none

module simd_fir_top
    import fir_pkg::*;
(
    input  wire             clock,
    input  wire             rst,

    // sample blocks from the host
    input  wire             block_write,
    input  wire block_t     block_in,
    output logic            space,

    // coefficient writes
    input  wire             coef_write,
    input  wire coef_addr_t coef_addr,
    input  wire coef_t      coef_data,

    // one output per sample
    output logic            y_valid,
    output acc_t            y
);

    window_if   bus ();
    coef_vec_t  coefs;

    window_sequencer u_seq (
        .clock       (clock),
        .rst         (rst),
        .block_write (block_write),
        .block_in    (block_in),
        .space       (space),
        .bus         (bus.seq)
    );

    sliding_window u_window (
        .clock (clock),
        .rst   (rst),
        .bus   (bus.win)
    );

    coef_bank u_coefs (
        .clock      (clock),
        .rst        (rst),
        .coef_write (coef_write),
        .coef_addr  (coef_addr),
        .coef_data  (coef_data),
        .coefs      (coefs)
    );

    mac_tree u_mac (
        .clock   (clock),
        .rst     (rst),
        .bus     (bus.tap),
        .coefs   (coefs),
        .y_valid (y_valid),
        .y       (y)
    );

endmodule

`default_nettype wire

// File: src/sliding_window.sv
// Sliding window
// a write window takes whole blocks, a read window gains one sample per read

`timescale 1ns/100ps
`default_nettype none

`include "fir_cfg.svh"

module sliding_window
    import fir_pkg::*;
(
    input  wire     clock,
    input  wire     rst,
    window_if.win   bus
);

    localparam int LANES = `FIR_LANES;

    // lane 0 is the next sample to leave
    block_t write_window;
    // lane 0 is the newest sample read
    block_t read_window;

    // write window
    always_ff @(posedge clock) begin
        if (rst) begin
            write_window <= '0;
        end else if (bus.write) begin
            // a concurrent read takes lane 0 before it is overwritten
            write_window <= bus.block;
        end else if (bus.read) begin
            for (int i = 0; i < LANES - 1; i++) begin
                write_window[i] <= write_window[i+1];
            end
            write_window[LANES-1] <= '0;
        end
    end

    // read window ages by one lane per read
    always_ff @(posedge clock) begin
        if (rst) begin
            read_window <= '0;
        end else if (bus.read) begin
            read_window[0] <= write_window[0];
            for (int i = 1; i < LANES; i++) begin
                read_window[i] <= read_window[i-1];
            end
        end
    end

    assign bus.window = read_window;

endmodule

`default_nettype wire

// File: src/window_if.sv
// Sliding window interface
// block loads and sample reads from the sequencer, read window out to the taps

`timescale 1ns/100ps
`default_nettype none

interface window_if
    import fir_pkg::*;
();

    // load strobe and its block
    logic   write;
    block_t block;

    // shift one sample into the read window
    logic   read;

    // read window, lane 0 newest
    block_t window;

    modport seq (
        output write,
        output block,
        output read
    );

    modport win (
        input  write,
        input  block,
        input  read,
        output window
    );

    modport tap (
        input  read,
        input  window
    );

endinterface

`default_nettype wire

// File: src/window_sequencer.sv
// Window sequencer
// holds one pending block and streams reads into the window without gaps

`timescale 1ns/100ps
`default_nettype none

`include "fir_cfg.svh"

module window_sequencer
    import fir_pkg::*;
(
    input  wire         clock,
    input  wire         rst,
    input  wire         block_write,
    input  wire block_t block_in,
    output logic        space,
    window_if.seq       bus
);

    localparam count_t FULL_COUNT = count_t'(`FIR_LANES);

    seq_state_t state;
    count_t     count;

    block_t     pending;
    logic       pending_full;

    logic       next_ready;
    block_t     next_block;
    logic       take;
    logic       store;

    // pending block first, else a block arriving this cycle goes straight through
    assign next_ready = pending_full || block_write;
    assign next_block = pending_full ? pending : block_in;

    // load when idle, or alongside the read of the last remaining sample
    always_comb begin
        case (state)
            seq_empty:  take = next_ready;
            seq_stream: take = next_ready && (count == count_t'(1));
            default:    take = 1'b0;
        endcase
    end

    // a host write is held unless it was taken directly
    assign store = block_write && (pending_full || !take);

    assign space     = !pending_full || take;
    assign bus.write = take;
    assign bus.block = next_block;
    assign bus.read  = (state == seq_stream);

    always_ff @(posedge clock) begin
        if (rst) begin
            pending_full <= 1'b0;
        end else begin
            pending_full <= (pending_full && !take) || store;
        end
    end

    always_ff @(posedge clock) begin
        if (store) begin
            pending <= block_in;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= seq_empty;
            count <= '0;
        end else begin
            case (state)
                seq_empty: begin
                    if (take) begin
                        state <= seq_stream;
                        count <= FULL_COUNT;
                    end
                end
                seq_stream: begin
                    if (take) begin
                        count <= FULL_COUNT;
                    end else if (count == count_t'(1)) begin
                        // last sample read, nothing waiting
                        state <= seq_empty;
                        count <= '0;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    state <= seq_empty;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verif/simd_fir_tb.sv
// SIMD FIR testbench
// streams sample blocks through the filter and checks every output against a reference FIR

`timescale 1ns/100ps
`default_nettype none

`include "fir_cfg.svh"

module simd_fir_tb
    import fir_pkg::*;
();

    localparam int LANES              = `FIR_LANES;
    localparam int RESET_CYCLES       = 8;
    localparam int SEED               = 41;
    localparam int BURST_BLOCKS       = 8;
    localparam int GAPPED_BLOCKS      = 8;
    localparam int RANDOM_BLOCKS      = 64;
    localparam int RESET_BLOCKS       = 3;
    localparam int AFTER_RESET_BLOCKS = 4;
    localparam int MAX_GAP            = 6;
    localparam int RANDOM_GAP         = 2;
    localparam int TOTAL_SAMPLES      = LANES * (1 + BURST_BLOCKS + GAPPED_BLOCKS
                                        + RANDOM_BLOCKS + RESET_BLOCKS + AFTER_RESET_BLOCKS);
    localparam int GAP_CYCLES         = GAPPED_BLOCKS * MAX_GAP + RANDOM_BLOCKS * RANDOM_GAP;
    localparam int TIMEOUT_CYCLES     = 2 * (TOTAL_SAMPLES + GAP_CYCLES) + 200;
    // two blocks in flight plus the pipeline, with margin
    localparam int DRAIN_CYCLES       = 4 * LANES + 8;

    logic       clock;
    logic       rst;
    logic       block_write;
    block_t     block_in;
    logic       space;
    logic       coef_write;
    coef_addr_t coef_addr;
    coef_t      coef_data;
    logic       y_valid;
    acc_t       y;

    // model of the filter history, newest at the back
    sample_t history [$];
    coef_t   coef_model [LANES];
    acc_t    expect_q [$];
    int      cycle_count;

    simd_fir_top dut0 (
        .clock       (clock),
        .rst         (rst),
        .block_write (block_write),
        .block_in    (block_in),
        .space       (space),
        .coef_write  (coef_write),
        .coef_addr   (coef_addr),
        .coef_data   (coef_data),
        .y_valid     (y_valid),
        .y           (y)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // sum over k of coefficient k times the sample k positions older
    function automatic acc_t fir_reference();
        longint acc;
        acc = 0;
        for (int k = 0; k < LANES; k++) begin
            acc += longint'($signed(coef_model[k]))
                   * longint'($signed(history[history.size() - 1 - k]));
        end
        return acc_t'(acc);
    endfunction

    function automatic block_t random_block();
        block_t b;
        for (int i = 0; i < LANES; i++) begin
            b[i] = sample_t'($urandom);
        end
        return b;
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic reset_model();
        history.delete();
        for (int i = 0; i < LANES - 1; i++) begin
            history.push_back(sample_t'(0));
        end
        for (int k = 0; k < LANES; k++) begin
            coef_model[k] = '0;
        end
        expect_q.delete();
    endtask

    task automatic write_coef(input int addr, input coef_t data);
        @(negedge clock);
        coef_write       = 1'b1;
        coef_addr        = coef_addr_t'(addr);
        coef_data        = data;
        coef_model[addr] = data;
        @(negedge clock);
        coef_write = 1'b0;
    endtask

    // strobe stays high until the next negedge where this task or another deasserts it
    task automatic send_block(input block_t b, input int gap);
        repeat (gap) begin
            @(negedge clock);
            block_write = 1'b0;
        end
        @(negedge clock);
        while (space !== 1'b1) begin
            block_write = 1'b0;
            @(negedge clock);
        end
        block_in    = b;
        block_write = 1'b1;
        for (int i = 0; i < LANES; i++) begin
            history.push_back(b[i]);
            expect_q.push_back(fir_reference());
        end
    endtask

    task automatic release_block_write();
        @(negedge clock);
        block_write = 1'b0;
    endtask

    task automatic wait_for_outputs();
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clock);
            waited++;
        end
        repeat (2) @(negedge clock);
    endtask

    task automatic watch_gapless(input int outputs);
        @(negedge clock);
        while (y_valid !== 1'b1) begin
            @(negedge clock);
        end
        repeat (outputs - 1) begin
            @(negedge clock);
            check(y_valid, 1, "y_valid during back-to-back blocks");
        end
    endtask

    task automatic apply_reset();
        @(negedge clock);
        block_write = 1'b0;
        rst         = 1'b1;
        // results still in the pipeline are dropped by the reset
        @(negedge clock);
        reset_model();
        repeat (RESET_CYCLES - 1) @(negedge clock);
        rst = 1'b0;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles before the tests finished", cycle_count);
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    // one expectation per output, in order
    initial begin
        forever begin
            @(negedge clock);
            if (y_valid === 1'b1) begin
                if (expect_q.size() == 0) begin
                    $display("Output at %0t arrived with no sample left to match it", $time);
                    $display("Test failures found");
                    $fatal(1, "unexpected output");
                end else begin
                    check(y, expect_q.pop_front(), "y");
                end
            end
        end
    end

    initial begin
        block_t b;
        int     gap;
        int     latency;
        void'($urandom(SEED));
        rst         = 1'b1;
        block_write = 1'b0;
        block_in    = '0;
        coef_write  = 1'b0;
        coef_addr   = '0;
        coef_data   = '0;
        reset_model();
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;

        // impulse through taps 1, 2, 3, 4 and first-output latency
        for (int k = 0; k < LANES; k++) begin
            write_coef(k, coef_t'(k + 1));
        end
        b    = '0;
        b[0] = sample_t'(1000);
        send_block(b, 0);
        latency = 0;
        do begin
            @(negedge clock);
            block_write = 1'b0;
            latency++;
        end while (y_valid !== 1'b1 && latency < 16);
        check(latency, 4, "first output latency");
        wait_for_outputs();

        // back-to-back blocks
        fork
            begin
                for (int i = 0; i < BURST_BLOCKS; i++) begin
                    send_block(random_block(), 0);
                end
                release_block_write();
            end
            watch_gapless(BURST_BLOCKS * LANES);
        join
        wait_for_outputs();

        // idle gaps between blocks
        for (int i = 0; i < GAPPED_BLOCKS; i++) begin
            gap = $urandom % (MAX_GAP + 1);
            send_block(random_block(), gap);
        end
        release_block_write();
        wait_for_outputs();

        // random signed taps, with most negative values mixed in
        write_coef(0, coef_t'(16'h8000));
        for (int k = 1; k < LANES; k++) begin
            write_coef(k, coef_t'($urandom));
        end
        for (int i = 0; i < RANDOM_BLOCKS; i++) begin
            b = random_block();
            if (i % 8 == 0) begin
                b[0] = sample_t'(16'h8000);
                b[1] = sample_t'(16'h7fff);
                b[2] = sample_t'(16'h8000);
                b[3] = sample_t'(16'h8000);
            end
            gap = (i % 4 == 0) ? $urandom % (RANDOM_GAP + 1) : 0;
            send_block(b, gap);
        end
        release_block_write();
        wait_for_outputs();

        // reset while blocks are pending and streaming
        for (int i = 0; i < RESET_BLOCKS; i++) begin
            send_block(random_block(), 0);
        end
        apply_reset();
        check(y_valid, 0, "y_valid after reset");
        check(space, 1, "space after reset");
        // tap 0 left unwritten, so it must have been cleared
        for (int k = 1; k < LANES; k++) begin
            write_coef(k, coef_t'($urandom));
        end
        for (int i = 0; i < AFTER_RESET_BLOCKS; i++) begin
            send_block(random_block(), 0);
        end
        release_block_write();
        wait_for_outputs();

        if (expect_q.size() != 0) begin
            $display("%0d expected outputs were never produced", expect_q.size());
            $display("Test failures found");
            $fatal(1, "missing outputs");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire
